// File: filelist.f
hw/addrGenPkg.sv
hw/busSampler.sv
hw/mainDecoder.sv
hw/subDecoder.sv
hw/watchdogIrq.sv
hw/cpuPhaseGen.sv
hw/selectDriver.sv
hw/cus41Top.sv
test/cus41_checker.sv
test/cus41Tb.sv

// File: hw/addrGenPkg.sv
`default_nettype none

package addrGenPkg;

	////////////////////
	// Bus types
	////////////////////

	// Upper address lines 15..11 of either CPU
	typedef logic [4:0] addrHi;

	// Count of vertical-blank falls since the last kick
	typedef logic [3:0] wdCount;

	// Sampled main CPU bus with write level active high
	typedef struct packed {
		addrHi addr;
		logic  write;
	} mainBusT;

	// Sampled sub CPU bus
	typedef struct packed {
		addrHi addr;
		logic  write;
	} subBusT;

	// Main CPU selects, active high inside the chip
	typedef struct packed {
		logic spriteRam;
		logic videoRam0;
		logic videoRam1;
		logic eeprom;
		logic progRom;
		logic latch0;
		logic latch1;
	} mainSelT;

	// Sub CPU selects
	typedef struct packed {
		logic cs0;
		logic cs1;
		logic cs2;
		logic cs3;
		logic cs4;
		logic rom;
	} subSelT;

	// Watchdog FSM
	typedef enum logic {
		running,
		tripped
	} wdState;

	////////////////////
	// Decode constants
	////////////////////

	// Count that wraps back to zero
	localparam wdCount wdLimit = 4'd10;
	// Count bit whose rise trips the main reset
	localparam int wdResetBit = 3;

	// Write-only strobes on the main bus
	localparam addrHi kickAddr = 5'b10000;     // 8000h
	localparam addrHi mainAckAddr = 5'b10001;  // 8800h
	// Sub CPU interrupt acknowledge
	localparam addrHi subAckAddr = 5'b10011;   // 9800h

	// Scroll and priority latch windows
	localparam addrHi latch0Addr = 5'b11010;   // D000h
	localparam addrHi latch1Addr = 5'b11011;   // D800h

endpackage

`default_nettype wire

// File: hw/busSampler.sv
`timescale 1ns/1ps
`default_nettype none

module busSampler (
	input  wire                 clk6M,
	input  wire                 arstN,
	input  wire addrGenPkg::addrHi ma,
	input  wire                 mWeN,
	input  wire addrGenPkg::addrHi sa,
	input  wire                 sWeN,
	input  wire                 vBlankN,
	output addrGenPkg::mainBusT mainBus,
	output addrGenPkg::subBusT  subBus,
	output logic                vBlankFall
);

	// vBlankN as seen on the last edge
	logic vbSample;
	// And the edge before that
	logic vbPrev;

	////////////////////
	// Bus registers
	////////////////////

	always_ff @(posedge clk6M or negedge arstN) begin
		if (!arstN) begin
			mainBus  <= '0;
			subBus   <= '0;
			// Idle high so reset release gives no false fall
			vbSample <= 1'b1;
			vbPrev   <= 1'b1;
		end else begin
			// Main CPU side
			mainBus.addr  <= ma;
			mainBus.write <= ~mWeN;
			// Sub CPU side
			subBus.addr   <= sa;
			subBus.write  <= ~sWeN;
			// Two-deep history of vertical blank
			vbSample      <= vBlankN;
			vbPrev        <= vbSample;
		end
	end

	////////////////////
	// Edge detect
	////////////////////

	// One cycle high after the sampled level drops
	assign vBlankFall = vbPrev & ~vbSample;

endmodule

`default_nettype wire

// File: hw/cpuPhaseGen.sv
`timescale 1ns/1ps
`default_nettype none

module cpuPhaseGen (
	input  wire  clk6M,
	input  wire  arstN,
	input  wire  clk0,
	output logic q
);

	// Registered copy of the CPU clock phase input
	logic       clk0Sample;
	// Free-running while clk0 is high, like a '161
	logic [3:0] phaseCount;

	////////////////////
	// Quadrature clock
	////////////////////

	always_ff @(posedge clk6M or negedge arstN) begin
		if (!arstN) begin
			clk0Sample <= 1'b0;
			phaseCount <= '0;
			q          <= 1'b0;
		end else begin
			clk0Sample <= clk0;
			// Held at zero while clk0 is low
			if (!clk0Sample) phaseCount <= '0;
			else phaseCount <= phaseCount + 4'd1;
			// Gray-coded low bits give the shifted phase
			q <= phaseCount[1] ^ phaseCount[0];
		end
	end

endmodule

`default_nettype wire

// File: hw/cus41Top.sv
`timescale 1ns/1ps
`default_nettype none

module cus41Top (
	input  wire                    clk6M,
	input  wire                    arstN,
	input  wire addrGenPkg::addrHi ma,
	input  wire                    mWeN,
	input  wire addrGenPkg::addrHi sa,
	input  wire                    sWeN,
	input  wire                    vBlankN,
	input  wire                    clk0,
	output wire                    mResetN,
	output wire                    mIntN,
	output wire                    sIntN,
	output wire                    q,
	output wire [4:0]              mCsN,
	output wire                    mRomN,
	output wire                    lth0N,
	output wire                    lth1N,
	output wire [4:0]              sCsN,
	output wire                    sRomN
);

	import addrGenPkg::*;

	// Sampled buses
	mainBusT mainBus;
	subBusT  subBus;
	logic    vBlankFall;
	// Decoded strobes
	logic    kick;
	logic    mainAck;
	logic    subAck;
	mainSelT mainSel;
	subSelT  subSel;

	////////////////////
	// Input side
	////////////////////

	busSampler iBusSampler (
		.clk6M(clk6M), .arstN(arstN),
		.ma(ma), .mWeN(mWeN), .sa(sa), .sWeN(sWeN), .vBlankN(vBlankN),
		.mainBus(mainBus), .subBus(subBus), .vBlankFall(vBlankFall)
	);

	////////////////////
	// Decode and timing
	////////////////////

	mainDecoder iMainDecoder (
		.mainBus(mainBus), .mainSel(mainSel), .kick(kick), .mainAck(mainAck)
	);

	subDecoder iSubDecoder (
		.subBus(subBus), .subSel(subSel), .subAck(subAck)
	);

	// Watchdog and both interrupt lines
	watchdogIrq iWatchdogIrq (
		.clk6M(clk6M), .arstN(arstN), .vBlankFall(vBlankFall),
		.kick(kick), .mainAck(mainAck), .subAck(subAck),
		.mResetN(mResetN), .mIntN(mIntN), .sIntN(sIntN)
	);

	cpuPhaseGen iCpuPhaseGen (
		.clk6M(clk6M), .arstN(arstN), .clk0(clk0), .q(q)
	);

	////////////////////
	// Output side
	////////////////////

	selectDriver iSelectDriver (
		.clk6M(clk6M), .arstN(arstN), .mainSel(mainSel), .subSel(subSel),
		.mCsN(mCsN), .mRomN(mRomN), .lth0N(lth0N), .lth1N(lth1N),
		.sCsN(sCsN), .sRomN(sRomN)
	);

endmodule

`default_nettype wire

// File: hw/mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
	input  wire addrGenPkg::mainBusT mainBus,
	output addrGenPkg::mainSelT      mainSel,
	output logic                     kick,
	output logic                     mainAck
);

	import addrGenPkg::*;

	// Local copies of the sampled bus fields
	addrHi addr;
	logic  write;

	assign addr  = mainBus.addr;
	assign write = mainBus.write;

	////////////////////
	// Chip selects
	////////////////////

	always_comb begin
		mainSel = '0;

		// Lower half in 8K blocks on A15..A13
		case (addr[4:2])
			// 0000h-1FFFh
			3'b000: mainSel.spriteRam = 1'b1;
			// 2000h-3FFFh
			3'b001: mainSel.videoRam0 = 1'b1;
			// 4000h-5FFFh
			3'b010: mainSel.videoRam1 = 1'b1;
			// 6000h-7FFFh
			3'b011: mainSel.eeprom = 1'b1;
			// Upper half handled below
			default: mainSel.eeprom = 1'b0;
		endcase

		// Program ROM 8000h-FFFFh, reads only
		mainSel.progRom = addr[4] & ~write;

		// Scroll and priority latches in 2K windows
		mainSel.latch0 = (addr == latch0Addr);
		mainSel.latch1 = (addr == latch1Addr);
	end

	////////////////////
	// Write strobes
	////////////////////

	// Watchdog kick at 8000h
	assign kick = write && (addr == kickAddr);

	// Main IRQ acknowledge at 8800h
	assign mainAck = write && (addr == mainAckAddr);

endmodule

`default_nettype wire

// File: hw/selectDriver.sv
`timescale 1ns/1ps
`default_nettype none

module selectDriver (
	input  wire                     clk6M,
	input  wire                     arstN,
	input  wire addrGenPkg::mainSelT mainSel,
	input  wire addrGenPkg::subSelT  subSel,
	output logic [4:0]              mCsN,
	output logic                    mRomN,
	output logic                    lth0N,
	output logic                    lth1N,
	output logic [4:0]              sCsN,
	output logic                    sRomN
);

	////////////////////
	// Pin registers
	////////////////////

	always_ff @(posedge clk6M or negedge arstN) begin
		if (!arstN) begin
			// Everything deselected
			mCsN  <= '1;
			mRomN <= 1'b1;
			lth0N <= 1'b1;
			lth1N <= 1'b1;
			sCsN  <= '1;
			sRomN <= 1'b1;
		end else begin
			// Board numbering, slot 3 has no device
			mCsN  <= ~{mainSel.eeprom, 1'b0, mainSel.spriteRam,
				mainSel.videoRam1, mainSel.videoRam0};
			mRomN <= ~mainSel.progRom;
			lth0N <= ~mainSel.latch0;
			lth1N <= ~mainSel.latch1;
			// Sub side in block order
			sCsN  <= ~{subSel.cs4, subSel.cs3, subSel.cs2, subSel.cs1, subSel.cs0};
			sRomN <= ~subSel.rom;
		end
	end

endmodule

`default_nettype wire

// File: hw/subDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module subDecoder (
	input  wire addrGenPkg::subBusT subBus,
	output addrGenPkg::subSelT      subSel,
	output logic                    subAck
);

	import addrGenPkg::*;

	addrHi addr;
	logic  write;

	assign addr  = subBus.addr;
	assign write = subBus.write;

	////////////////////
	// Chip selects
	////////////////////

	always_comb begin
		subSel = '0;

		// Five 8K blocks from the bottom of the map
		case (addr[4:2])
			3'b000: subSel.cs0 = 1'b1;
			3'b001: subSel.cs1 = 1'b1;
			3'b010: subSel.cs2 = 1'b1;
			3'b011: subSel.cs3 = 1'b1;
			// 8000h-9FFFh
			3'b100: subSel.cs4 = 1'b1;
			// A000h and up belongs to the ROM
			default: subSel.cs4 = 1'b0;
		endcase

		// ROM A000h-FFFFh on reads
		subSel.rom = addr[4] & (addr[3] | addr[2]) & ~write;
	end

	////////////////////
	// Write strobe
	////////////////////

	// Sub IRQ acknowledge at 9800h
	assign subAck = write && (addr == subAckAddr);

endmodule

`default_nettype wire

// File: hw/watchdogIrq.sv
`timescale 1ns/1ps
`default_nettype none

module watchdogIrq (
	input  wire  clk6M,
	input  wire  arstN,
	input  wire  vBlankFall,
	input  wire  kick,
	input  wire  mainAck,
	input  wire  subAck,
	output logic mResetN,
	output logic mIntN,
	output logic sIntN
);

	import addrGenPkg::*;

	wdCount count;
	wdCount countNext;
	wdState state;
	wdState stateNext;
	// IRQ latches, active high
	logic   mainIrq;
	logic   subIrq;

	////////////////////
	// Watchdog
	////////////////////

	// Kick beats a vertical-blank fall in the same cycle
	always_comb begin
		countNext = count;
		if (kick) begin
			countNext = '0;
		end else if (vBlankFall) begin
			countNext = count + 4'd1;
			// Wrap at the limit
			if (countNext == wdLimit) begin
				countNext = '0;
			end
		end
	end

	// Trip on the reset bit, release on wrap or kick
	always_comb begin
		stateNext = state;
		case (state)
			running: if (countNext[wdResetBit]) stateNext = tripped;
			tripped: if (countNext == '0) stateNext = running;
			default: stateNext = running;
		endcase
	end

	always_ff @(posedge clk6M or negedge arstN) begin
		if (!arstN) begin
			count   <= '0;
			state   <= running;
			mainIrq <= 1'b0;
			subIrq  <= 1'b0;
			// Pins idle high
			mResetN <= 1'b1;
			mIntN   <= 1'b1;
			sIntN   <= 1'b1;
		end else begin
			count <= countNext;
			state <= stateNext;
			// Ack has priority over a new request
			if (mainAck) mainIrq <= 1'b0;
			else if (vBlankFall) mainIrq <= 1'b1;
			if (subAck) subIrq <= 1'b0;
			else if (vBlankFall) subIrq <= 1'b1;
			// Output stage
			mResetN <= (state != tripped);
			mIntN   <= ~mainIrq;
			sIntN   <= ~subIrq;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cus41Tb -f filelist.f -o cus41Sim \
	|| { echo "build failed"; exit 1; }
result=$(./obj_dir/cus41Sim 2>&1)
echo "$result"
echo "$result" | grep -q "^TEST PASSED$" && exit 0 || exit 1

// File: test/cus41Tb.sv
`timescale 1ns/1ps
`default_nettype none

module cus41Tb;

	import addrGenPkg::*;

	// One row of the stimulus table
	typedef struct {
		string      name;
		addrHi      ma;
		logic       mWeN;
		addrHi      sa;
		logic       sWeN;
		logic       vBlankN;
		logic       clk0;
		int         waits;
		mainSelT    expMain;
		subSelT     expSub;
		// mResetN, mIntN, sIntN
		logic [2:0] expCtl;
	} stepT;

	localparam int tableLen = 11;
	localparam int maxWait = 3;
	localparam int lfsrRuns = 40;
	// Vertical-blank loops, six cycles each
	localparam int blankRuns = 30;
	localparam int blankLen = 6;
	localparam int timeoutCycles = 8 + tableLen * maxWait + lfsrRuns * 2
		+ blankRuns * blankLen + 32 + 100;

	logic        clk6M;
	logic        arstN;
	addrHi       ma;
	addrHi       sa;
	logic        mWeN;
	logic        sWeN;
	logic        vBlankN;
	logic        clk0;
	logic        mResetN;
	logic        mIntN;
	logic        sIntN;
	logic        q;
	logic [4:0]  mCsN;
	logic [4:0]  sCsN;
	logic        mRomN;
	logic        lth0N;
	logic        lth1N;
	logic        sRomN;
	stepT        steps[tableLen];
	logic [31:0] lfsrState = 32'h24570a74;
	int          cycleCount = 0;

	cus41Top i_dut (
		.clk6M(clk6M), .arstN(arstN), .ma(ma), .mWeN(mWeN), .sa(sa), .sWeN(sWeN),
		.vBlankN(vBlankN), .clk0(clk0), .mResetN(mResetN), .mIntN(mIntN), .sIntN(sIntN),
		.q(q), .mCsN(mCsN), .mRomN(mRomN), .lth0N(lth0N), .lth1N(lth1N),
		.sCsN(sCsN), .sRomN(sRomN)
	);

	initial begin
		clk6M = 1'b0;
		forever #20 clk6M = ~clk6M;
	end

	// Run limit
	always @(posedge clk6M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the run took more than %0d cycles", timeoutCycles);
			stopRun();
		end
	end

	////////////////////
	// Reference models
	////////////////////

	// Main map on full 16-bit addresses
	function automatic mainSelT mainMap(input addrHi a, input logic wr);
		logic [15:0] adr;
		mainSelT     s;
		adr = {a, 11'h000};
		s.spriteRam = adr < 16'h2000;
		s.videoRam0 = adr >= 16'h2000 && adr < 16'h4000;
		s.videoRam1 = adr >= 16'h4000 && adr < 16'h6000;
		s.eeprom = adr >= 16'h6000 && adr < 16'h8000;
		s.progRom = adr >= 16'h8000 && !wr;
		s.latch0 = adr >= 16'hD000 && adr < 16'hD800;
		s.latch1 = adr >= 16'hD800 && adr < 16'hE000;
		return s;
	endfunction

	function automatic subSelT subMap(input addrHi a, input logic wr);
		logic [15:0] adr;
		subSelT      s;
		adr = {a, 11'h000};
		s.cs0 = adr < 16'h2000;
		s.cs1 = adr >= 16'h2000 && adr < 16'h4000;
		s.cs2 = adr >= 16'h4000 && adr < 16'h6000;
		s.cs3 = adr >= 16'h6000 && adr < 16'h8000;
		s.cs4 = adr >= 16'h8000 && adr < 16'hA000;
		s.rom = adr >= 16'hA000 && !wr;
		return s;
	endfunction

	// q seen k falling edges after clk0 goes high
	// Low at first, then high for two and low for two
	function automatic logic expectedQ(input int k);
		if (k < 3) return 1'b0;
		return ((k - 3) / 2) % 2 == 0;
	endfunction

	// Right-shifting Galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = nextLfsr(lfsrState);
		end
	endtask

	////////////////////
	// Compare tasks
	////////////////////

	task automatic stopRun();
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkMainSel(input string name, input mainSelT expected);
		mainSelT actual;
		// Board pin order, slot 3 unused
		actual = ~{mCsN[2], mCsN[0], mCsN[1], mCsN[4], mRomN, lth0N, lth1N};
		if (actual !== expected) begin
			$display("FAILED %s: main selects expected %b, actual %b", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkSubSel(input string name, input subSelT expected);
		subSelT actual;
		actual = ~{sCsN[0], sCsN[1], sCsN[2], sCsN[3], sCsN[4], sRomN};
		if (actual !== expected) begin
			$display("FAILED %s: sub selects expected %b, actual %b", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			stopRun();
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic fillTable();
		steps[0] = '{"sprite rd", 5'h00, 1'b1, 5'h00, 1'b1, 1'b1, 1'b0, 2,
			7'b1000000, 6'b100000, 3'b111};
		steps[1] = '{"vram0 wr", 5'h04, 1'b0, 5'h04, 1'b0, 1'b1, 1'b0, 2,
			7'b0100000, 6'b010000, 3'b111};
		steps[2] = '{"vram1 rd", 5'h08, 1'b1, 5'h08, 1'b1, 1'b1, 1'b0, 2,
			7'b0010000, 6'b001000, 3'b111};
		steps[3] = '{"eeprom rd", 5'h0C, 1'b1, 5'h0C, 1'b1, 1'b1, 1'b0, 2,
			7'b0001000, 6'b000100, 3'b111};
		steps[4] = '{"rom rd", 5'h10, 1'b1, 5'h10, 1'b1, 1'b1, 1'b0, 2,
			7'b0000100, 6'b000010, 3'b111};
		// Latch write hides the program ROM
		steps[5] = '{"latch0 wr", 5'h1A, 1'b0, 5'h14, 1'b1, 1'b1, 1'b0, 2,
			7'b0000010, 6'b000001, 3'b111};
		steps[6] = '{"latch1 rd", 5'h1B, 1'b1, 5'h1F, 1'b0, 1'b1, 1'b0, 2,
			7'b0000101, 6'b000000, 3'b111};
		// Interrupts, three cycles each
		steps[7] = '{"vblank fall", 5'h00, 1'b1, 5'h00, 1'b1, 1'b0, 1'b0, 3,
			7'b1000000, 6'b100000, 3'b100};
		steps[8] = '{"main ack", 5'h11, 1'b0, 5'h00, 1'b1, 1'b0, 1'b0, 3,
			7'b0000000, 6'b100000, 3'b110};
		steps[9] = '{"sub ack", 5'h00, 1'b1, 5'h13, 1'b0, 1'b1, 1'b0, 3,
			7'b1000000, 6'b000010, 3'b111};
		steps[10] = '{"rom wr", 5'h1F, 1'b0, 5'h1F, 1'b1, 1'b1, 1'b0, 2,
			7'b0000000, 6'b000001, 3'b111};
	endtask

	task automatic applyStep(input stepT s);
		ma = s.ma;
		mWeN = s.mWeN;
		sa = s.sa;
		sWeN = s.sWeN;
		vBlankN = s.vBlankN;
		clk0 = s.clk0;
		repeat (s.waits) @(negedge clk6M);
		checkMainSel(s.name, s.expMain);
		checkSubSel(s.name, s.expSub);
		checkBit({s.name, " cs3"}, 1'b1, mCsN[3]);
		checkBit({s.name, " mResetN"}, s.expCtl[2], mResetN);
		checkBit({s.name, " mIntN"}, s.expCtl[1], mIntN);
		checkBit({s.name, " sIntN"}, s.expCtl[0], sIntN);
	endtask

	// Optional kick, then one vertical-blank fall
	task automatic blankCycle(input logic withKick);
		ma = withKick ? kickAddr : 5'h00;
		mWeN = ~withKick;
		vBlankN = 1'b1;
		@(negedge clk6M);
		ma = 5'h00;
		mWeN = 1'b1;
		repeat (2) @(negedge clk6M);
		vBlankN = 1'b0;
		// Pins settle three cycles after the fall
		repeat (3) @(negedge clk6M);
	endtask

	initial begin
		logic [31:0] bits;
		arstN = 1'b0;
		ma = '0;
		mWeN = 1'b1;
		sa = '0;
		sWeN = 1'b1;
		vBlankN = 1'b1;
		clk0 = 1'b0;
		fillTable();
		repeat (8) @(posedge clk6M);
		@(negedge clk6M);
		arstN = 1'b1;

		for (int i = 0; i < tableLen; i++) begin
			applyStep(steps[i]);
		end

		// Random addresses against both maps
		for (int i = 0; i < lfsrRuns; i++) begin
			takeBits(12, bits);
			ma = bits[11:7];
			mWeN = bits[6];
			sa = bits[5:1];
			sWeN = bits[0];
			repeat (2) @(negedge clk6M);
			checkMainSel($sformatf("random main %0d", i), mainMap(bits[11:7], ~bits[6]));
			checkSubSel($sformatf("random sub %0d", i), subMap(bits[5:1], ~bits[0]));
		end
		sa = '0;
		sWeN = 1'b1;

		// Watchdog left alone after one kick
		for (int n = 1; n <= 10; n++) begin
			blankCycle(n == 1);
			checkBit($sformatf("watchdog fall %0d", n), !(n >= 8 && n < 10), mResetN);
		end
		for (int n = 1; n <= 20; n++) begin
			blankCycle(1'b1);
			checkBit($sformatf("kicked fall %0d", n), 1'b1, mResetN);
		end

		// Quadrature clock
		for (int k = 1; k <= 4; k++) begin
			@(negedge clk6M);
			checkBit("q idle", 1'b0, q);
		end
		clk0 = 1'b1;
		for (int k = 1; k <= 12; k++) begin
			@(negedge clk6M);
			checkBit($sformatf("q phase %0d", k), expectedQ(k), q);
		end
		clk0 = 1'b0;
		repeat (3) @(negedge clk6M);
		for (int k = 1; k <= 4; k++) begin
			@(negedge clk6M);
			checkBit("q held", 1'b0, q);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/cus41_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cus41Checker (
	input wire       clk6M,
	input wire       arstN,
	input wire       mainAck,
	input wire       subAck,
	input wire       mResetN,
	input wire       mIntN,
	input wire       sIntN,
	input wire       q,
	input wire [4:0] mCsN,
	input wire       mRomN,
	input wire       lth0N,
	input wire       lth1N,
	input wire [4:0] sCsN,
	input wire       sRomN
);

	// Every pin parks inactive on the edge after reset is seen
	resetIdle: assert property (@(posedge clk6M) !arstN |=> (mResetN && mIntN && sIntN
		&& !q && (&mCsN) && mRomN && lth0N && lth1N && (&sCsN) && sRomN))
		else $error("pins active during reset");

	// Main RAM, EEPROM and ROM selects never overlap
	oneMainCs: assert property (@(posedge clk6M) disable iff (!arstN)
		$countones({~mCsN, ~mRomN}) <= 1)
		else $error("more than one main select low");

	// Ack pulse lands two edges before the pin is seen high
	mIntRelease: assert property (@(posedge clk6M) disable iff (!arstN)
		$rose(mIntN) |-> $past(mainAck, 2))
		else $error("mIntN released without a main ack");

	sIntRelease: assert property (@(posedge clk6M) disable iff (!arstN)
		$rose(sIntN) |-> $past(subAck, 2))
		else $error("sIntN released without a sub ack");

endmodule

bind cus41Top cus41Checker iChecker (
	.clk6M(clk6M), .arstN(arstN), .mainAck(mainAck), .subAck(subAck),
	.mResetN(mResetN), .mIntN(mIntN), .sIntN(sIntN), .q(q),
	.mCsN(mCsN), .mRomN(mRomN), .lth0N(lth0N), .lth1N(lth1N),
	.sCsN(sCsN), .sRomN(sRomN)
);

`default_nettype wire
